/* common/vsum_pkg.sv */
package vsum_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Byte address and data width of the bus
  localparam int WB_ADDR_W = 8;
  localparam int WB_DATA_W = 32;

  // Accumulator count and largest vector count
  localparam int MAX_LEN = 16;
  localparam int MAX_VEC = 16;

  ////////////////////////////////////////
  // Register map
  ////////////////////////////////////////

  localparam logic [WB_ADDR_W-1:0] REG_CTRL        = 8'h00;
  localparam logic [WB_ADDR_W-1:0] REG_STATUS      = 8'h04;
  localparam logic [WB_ADDR_W-1:0] REG_DATA        = 8'h08;
  // Sum j sits at base plus 4*j
  localparam logic [WB_ADDR_W-1:0] REG_RESULT_BASE = 8'h40;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [WB_ADDR_W-1:0] wb_addr_t;
  typedef logic [WB_DATA_W-1:0] word_t;
  // Count of vectors or elements, 1 to 16
  typedef logic [4:0]           count_t;
  // Accumulator or vector index
  typedef logic [3:0]           index_t;

  // Run request from the CTRL register
  typedef struct packed {
    logic   start;
    count_t size;
    count_t length;
  } run_cfg_t;

  // One element from the DATA register
  typedef struct packed {
    logic  valid;
    word_t data;
  } elem_t;

  // Write into the accumulator bank
  typedef struct packed {
    logic   en;
    logic   load;
    index_t index;
    word_t  data;
  } acc_op_t;

  typedef struct packed {
    logic busy;
    logic done;
    logic dropped;
  } run_status_t;

  typedef enum logic [1:0] {
    IDLE,
    COLLECT,
    DONE
  } sum_state_e;

endpackage

/* vector_summation/accumulator_bank.sv */
`timescale 1ns/1ps

module accumulator_bank
  import vsum_pkg::*;
(
  input  logic    CLK,
  input  logic    RST,
  input  acc_op_t acc_op,
  input  index_t  rd_index,
  output word_t   rd_data
);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // One running sum per element position
  word_t acc [MAX_LEN];

  // Current value at the write index
  word_t cur;
  // Value to store back
  word_t nxt;

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  assign cur = acc[acc_op.index];

  // Load on the first vector, wrap-around add after
  always_comb begin
    if (acc_op.load) begin
      nxt = acc_op.data;
    end else begin
      nxt = cur + acc_op.data;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < MAX_LEN; i++) begin
        acc[i] <= '0;
      end
    end else if (acc_op.en) begin
      acc[acc_op.index] <= nxt;
    end
  end

  ////////////////////////////////////////
  // Read port
  ////////////////////////////////////////

  // Asynchronous, registered by the bus slave
  assign rd_data = acc[rd_index];

endmodule

/* vector_summation/vector_sum_ctrl.sv */
`timescale 1ns/1ps

module vector_sum_ctrl
  import vsum_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  input  run_cfg_t    run_cfg,
  input  elem_t       elem,
  output acc_op_t     acc_op,
  output run_status_t status
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  sum_state_e state;

  // Latched run shape
  count_t size_q;
  count_t len_q;

  // Vector index and scalar index
  index_t vec_idx;
  index_t scal_idx;

  // Status flags
  logic busy_q;
  logic done_q;
  logic dropped_q;

  // Accumulator write, split into control and payload
  logic   op_en;
  logic   op_load;
  index_t op_index;
  word_t  op_data;

  logic last_scalar;
  logic last_vector;

  // Zero counts as one, oversize clips to the limit
  function automatic count_t norm_count(count_t c, int limit);
    count_t r;
    r = c;
    if (c == '0) r = count_t'(1);
    else if (int'(c) > limit) r = count_t'(limit);
    return r;
  endfunction

  ////////////////////////////////////////
  // Run FSM
  ////////////////////////////////////////

  // End of a vector and end of the run
  assign last_scalar = (count_t'(scal_idx) == len_q - count_t'(1));
  assign last_vector = (count_t'(vec_idx) == size_q - count_t'(1));

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= IDLE;
      size_q    <= count_t'(1);
      len_q     <= count_t'(1);
      vec_idx   <= '0;
      scal_idx  <= '0;
      busy_q    <= 1'b0;
      done_q    <= 1'b0;
      dropped_q <= 1'b0;
      op_en     <= 1'b0;
    end else begin
      // Write strobe lasts one cycle
      op_en <= 1'b0;
      if (run_cfg.start) begin
        // New run, from any state
        state     <= COLLECT;
        size_q    <= norm_count(run_cfg.size, MAX_VEC);
        len_q     <= norm_count(run_cfg.length, MAX_LEN);
        vec_idx   <= '0;
        scal_idx  <= '0;
        busy_q    <= 1'b1;
        done_q    <= 1'b0;
        dropped_q <= 1'b0;
      end else if (elem.valid) begin
        if (state == COLLECT) begin
          op_en <= 1'b1;
          if (last_scalar) begin
            // Wrap to the next vector
            scal_idx <= '0;
            vec_idx  <= vec_idx + index_t'(1);
            if (last_vector) begin
              state  <= DONE;
              busy_q <= 1'b0;
              done_q <= 1'b1;
            end
          end else begin
            scal_idx <= scal_idx + index_t'(1);
          end
        end else begin
          // No run open, element is lost
          dropped_q <= 1'b1;
        end
      end
    end
  end

  // Payload, only meaningful with op_en
  always_ff @(posedge CLK) begin
    if (elem.valid) begin
      // First vector loads rather than adds
      op_load  <= (vec_idx == '0);
      op_index <= scal_idx;
      op_data  <= elem.data;
    end
  end

  assign acc_op = '{en: op_en, load: op_load, index: op_index, data: op_data};
  assign status = '{busy: busy_q, done: done_q, dropped: dropped_q};

endmodule

/* verilog/wb_vsum_regs.sv */
`timescale 1ns/1ps

module wb_vsum_regs
  import vsum_pkg::*;
(
  input  logic        CLK,
  input  logic        RST,
  // Wishbone classic slave
  input  logic        cyc,
  input  logic        stb,
  input  logic        we,
  input  wb_addr_t    adr,
  input  word_t       dat_w,
  input  logic [3:0]  sel,
  output word_t       dat_r,
  output logic        ack,
  // Controller side
  output run_cfg_t    run_cfg,
  output elem_t       elem,
  input  run_status_t status,
  // Accumulator read port
  output index_t      rd_index,
  input  word_t       rd_data
);

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  // New request, not yet acknowledged
  logic req;
  logic hit_result;
  word_t rd_word;

  // Registered strobes
  logic start_q;
  logic valid_q;

  // Registered payload
  count_t size_q;
  count_t len_q;
  word_t  data_q;

  assign req = cyc & stb & ~ack;

  // Sums occupy 0x40 to 0x7c, word aligned
  assign hit_result = (adr[7:6] == REG_RESULT_BASE[7:6]) && (adr[1:0] == 2'b00);
  assign rd_index   = adr[5:2];

  // Read mux, zero when unmapped
  always_comb begin
    rd_word = '0;
    if (adr == REG_STATUS) begin
      rd_word = {{(WB_DATA_W-3){1'b0}}, status.dropped, status.done, status.busy};
    end else if (hit_result) begin
      rd_word = rd_data;
    end
  end

  ////////////////////////////////////////
  // Ack and strobes
  ////////////////////////////////////////

  // Full-word access only, sel lanes not decoded
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ack     <= 1'b0;
      start_q <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      ack     <= req;
      start_q <= req & we & (adr == REG_CTRL);
      valid_q <= req & we & (adr == REG_DATA);
    end
  end

  // Payload captured alongside the strobes
  always_ff @(posedge CLK) begin
    if (req) begin
      size_q <= dat_w[4:0];
      len_q  <= dat_w[12:8];
      data_q <= dat_w;
      // Read data lands with ack
      if (!we) begin
        dat_r <= rd_word;
      end
    end
  end

  assign run_cfg = '{start: start_q, size: size_q, length: len_q};
  assign elem    = '{valid: valid_q, data: data_q};

endmodule

/* verilog/vsum_top.sv */
`timescale 1ns/1ps

module vsum_top
  import vsum_pkg::*;
(
  input  logic       CLK,
  input  logic       RST,
  input  logic       cyc,
  input  logic       stb,
  input  logic       we,
  input  wb_addr_t   adr,
  input  word_t      dat_w,
  input  logic [3:0] sel,
  output word_t      dat_r,
  output logic       ack
);

  ////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////

  run_cfg_t    run_cfg;
  elem_t       elem;
  acc_op_t     acc_op;
  run_status_t status;
  index_t      rd_index;
  word_t       rd_data;

  // Bus slave and register file
  wb_vsum_regs u_regs (
    .CLK      (CLK),
    .RST      (RST),
    .cyc      (cyc),
    .stb      (stb),
    .we       (we),
    .adr      (adr),
    .dat_w    (dat_w),
    .sel      (sel),
    .dat_r    (dat_r),
    .ack      (ack),
    .run_cfg  (run_cfg),
    .elem     (elem),
    .status   (status),
    .rd_index (rd_index),
    .rd_data  (rd_data)
  );

  // Run FSM
  vector_sum_ctrl u_ctrl (
    .CLK     (CLK),
    .RST     (RST),
    .run_cfg (run_cfg),
    .elem    (elem),
    .acc_op  (acc_op),
    .status  (status)
  );

  // Running sums
  accumulator_bank u_bank (
    .CLK      (CLK),
    .RST      (RST),
    .acc_op   (acc_op),
    .rd_index (rd_index),
    .rd_data  (rd_data)
  );

endmodule

/* verification/vsum_assertions.sv */
`timescale 1ns/1ps

module vsum_assertions
  import vsum_pkg::*;
(
  input logic        CLK,
  input logic        RST,
  input logic        cyc,
  input logic        stb,
  input logic        ack,
  input sum_state_e  state,
  input acc_op_t     acc_op,
  input run_status_t status,
  input count_t      len
);

  ////////////////////////////////////////
  // Bus handshake
  ////////////////////////////////////////

  // Single-cycle ack
  ack_pulse: assert property (@(posedge CLK) disable iff (RST) ack |=> !ack)
    else $error("ack held high for more than one cycle");

  // Ack answers a request from the cycle before
  ack_after_req: assert property (@(posedge CLK) disable iff (RST) ack |-> $past(cyc && stb))
    else $error("ack without a preceding cyc and stb request");

  ////////////////////////////////////////
  // Controller
  ////////////////////////////////////////

  no_op_in_idle: assert property (@(posedge CLK) disable iff (RST) acc_op.en |-> state != IDLE)
    else $error("accumulator write issued while idle");

  busy_or_done: assert property (@(posedge CLK) disable iff (RST) !(status.busy && status.done))
    else $error("busy and done both set");

  // Writes stay inside the latched length
  index_in_range: assert property (@(posedge CLK) disable iff (RST)
                                   acc_op.en |-> count_t'(acc_op.index) < len)
    else $error("accumulator index beyond the run length");

endmodule

// Bus slave ports and controller state seen from the top level
bind vsum_top vsum_assertions u_checks (
  .CLK    (CLK),
  .RST    (RST),
  .cyc    (cyc),
  .stb    (stb),
  .ack    (ack),
  .state  (u_ctrl.state),
  .acc_op (acc_op),
  .status (status),
  .len    (u_ctrl.len_q)
);

/* verification/vsum_tb.sv */
`timescale 1ns/1ps

module vsum_tb
  import vsum_pkg::*;
();

  ////////////////////////////////////////
  // Timing and budget
  ////////////////////////////////////////

  localparam int CLK_PERIOD = 4;
  localparam int RESET_CYCLES = 3;
  // Status reads allowed before a run counts as stuck
  localparam int POLL_MAX = 8;

  // Bus accesses per test, polls at their limit
  localparam int ACC_RESET   = 17;
  localparam int ACC_SINGLE  = 18 + POLL_MAX;
  localparam int ACC_WRAP    = 273 + POLL_MAX;
  localparam int ACC_B2B     = 22 + 2 * POLL_MAX;
  localparam int ACC_DROP    = 20;
  localparam int ACC_UNMAP   = 24;
  localparam int BUS_ACCESSES = ACC_RESET + ACC_SINGLE + ACC_WRAP + ACC_B2B + ACC_DROP + ACC_UNMAP;
  localparam int WATCHDOG_CYCLES = 20 * BUS_ACCESSES + RESET_CYCLES;

  ////////////////////////////////////////
  // DUT and bus signals
  ////////////////////////////////////////

  logic       CLK;
  logic       RST;
  logic       cyc;
  logic       stb;
  logic       we;
  wb_addr_t   adr;
  word_t      dat_w;
  logic [3:0] sel;
  word_t      dat_r;
  logic       ack;

  // Expected sums
  word_t model [MAX_LEN];
  word_t rd;
  int unsigned seed_ret;

  vsum_top dut (
    .CLK   (CLK),
    .RST   (RST),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .dat_w (dat_w),
    .sel   (sel),
    .dat_r (dat_r),
    .ack   (ack)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  ////////////////////////////////////////
  // Bus tasks
  ////////////////////////////////////////

  // Ack sampled mid-cycle, away from the edge
  task automatic wait_ack();
    @(negedge CLK);
    while (!ack) @(negedge CLK);
  endtask

  task automatic wb_write(input wb_addr_t a, input word_t d);
    @(posedge CLK);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= 1'b1;
    adr   <= a;
    dat_w <= d;
    sel   <= 4'hf;
    wait_ack();
    // Drop the request on the edge that clears ack
    @(posedge CLK);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic wb_read(input wb_addr_t a, output word_t d);
    @(posedge CLK);
    cyc <= 1'b1;
    stb <= 1'b1;
    we  <= 1'b0;
    adr <= a;
    sel <= 4'hf;
    wait_ack();
    // Read data arrives together with ack
    d = dat_r;
    @(posedge CLK);
    cyc <= 1'b0;
    stb <= 1'b0;
  endtask

  task automatic check_equal(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("Checks failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Poll STATUS until the done bit shows
  task automatic wait_done();
    word_t st;
    int polls;
    st = '0;
    polls = 0;
    while (st[1] !== 1'b1) begin
      if (polls == POLL_MAX) begin
        $display("Run did not report done within %0d status reads", POLL_MAX);
        $display("Checks failed");
        $fatal(1, "run stuck");
      end
      wb_read(REG_STATUS, st);
      polls++;
    end
  endtask

  ////////////////////////////////////////
  // Run helpers
  ////////////////////////////////////////

  // Size in bits 4..0, length in bits 12..8
  task automatic start_run(input count_t size, input count_t length);
    word_t w;
    w = '0;
    w[4:0]  = size;
    w[12:8] = length;
    wb_write(REG_CTRL, w);
  endtask

  // Starts a run and streams its elements in row order
  task automatic run_vectors(input int n_vec, input int len, input word_t base,
                             input word_t span);
    word_t e;
    start_run(count_t'(n_vec), count_t'(len));
    for (int v = 0; v < n_vec; v++) begin
      for (int j = 0; j < len; j++) begin
        e = base + ($urandom & span);
        // First vector overwrites, later ones wrap-add
        if (v == 0) model[j] = e;
        else model[j] = model[j] + e;
        wb_write(REG_DATA, e);
      end
    end
  endtask

  task automatic check_sums(input int count);
    for (int j = 0; j < count; j++) begin
      wb_read(wb_addr_t'(int'(REG_RESULT_BASE) + 4 * j), rd);
      check_equal($sformatf("sum[%0d]", j), rd, model[j]);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic reset_state();
    wb_read(REG_STATUS, rd);
    check_equal("status", rd, 32'h0);
    check_sums(MAX_LEN);
  endtask

  task automatic single_run();
    run_vectors(3, 4, 32'h0, 32'hffff_ffff);
    wait_done();
    check_sums(4);
    // Done only, busy cleared
    wb_read(REG_STATUS, rd);
    check_equal("status", rd, 32'h2);
  endtask

  // Elements near the signed maximum force wrap
  task automatic wrap_full_size();
    run_vectors(MAX_VEC, MAX_LEN, 32'h7fff_ff00, 32'h0000_00ff);
    wait_done();
    check_sums(MAX_LEN);
  endtask

  task automatic back_to_back_runs();
    run_vectors(3, 4, 32'h0, 32'hffff_ffff);
    wait_done();
    // Length 2 leaves sums 2 and 3 alone
    run_vectors(2, 2, 32'h0, 32'h0000_ffff);
    wait_done();
    check_sums(4);
  endtask

  task automatic dropped_elements();
    wb_write(REG_DATA, $urandom);
    wb_read(REG_STATUS, rd);
    check_equal("status", rd, 32'h6);
    check_sums(MAX_LEN);
    // New run clears dropped and leaves busy
    start_run(count_t'(1), count_t'(1));
    wb_read(REG_STATUS, rd);
    check_equal("status", rd, 32'h1);
  endtask

  task automatic unmapped_accesses();
    wb_read(8'h0c, rd);
    check_equal("rd 0x0c", rd, 32'h0);
    wb_read(8'h20, rd);
    check_equal("rd 0x20", rd, 32'h0);
    wb_read(8'h80, rd);
    check_equal("rd 0x80", rd, 32'h0);
    wb_read(8'hfc, rd);
    check_equal("rd 0xfc", rd, 32'h0);
    // Misaligned inside the sum window
    wb_read(8'h41, rd);
    check_equal("rd 0x41", rd, 32'h0);
    wb_write(REG_STATUS, 32'hffff_ffff);
    wb_write(8'h80, 32'h1234_5678);
    wb_read(REG_STATUS, rd);
    check_equal("status", rd, 32'h1);
    check_sums(MAX_LEN);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    seed_ret = $urandom(32'hc530_7e3e);
    RST   = 1'b1;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    dat_w = '0;
    sel   = '0;
    for (int j = 0; j < MAX_LEN; j++) model[j] = '0;
    repeat (RESET_CYCLES) @(posedge CLK);
    RST <= 1'b0;
    reset_state();
    single_run();
    wrap_full_size();
    back_to_back_runs();
    dropped_elements();
    unmapped_accesses();
    $display("All checks passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timed out after %0d cycles before the tests finished", WATCHDOG_CYCLES);
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

endmodule

/* vsum.f */
common/vsum_pkg.sv
vector_summation/accumulator_bank.sv
vector_summation/vector_sum_ctrl.sv
verilog/wb_vsum_regs.sv
verilog/vsum_top.sv
verification/vsum_assertions.sv
verification/vsum_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := vsum_tb
FILELIST  := vsum.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)

# Sources taken from the file list, options dropped
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# Exit status of the simulator is the result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
